/* src/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Operations and paths
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_MOD,
        OP_MODU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BLTU,
        OP_JAL
    } ex_op_e;

    // Which unit produces the result of the held request
    typedef enum logic [1:0] {
        PATH_ALU,
        PATH_MUL,
        PATH_DIV
    } ex_path_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage interfaces
    ////////////////////////////////////////////////////////////////////////////

    // src2 already carries the immediate for ALU ops, imm is the branch offset
    typedef struct packed {
        ex_op_e          op;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd;
        logic            wen;
        logic            pred_taken;
    } ex_req_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            wen;
        logic [XLEN-1:0] wdata;
    } ex_result_t;

    typedef struct packed {
        logic [XLEN-1:0] branch_pc;
        logic [XLEN-1:0] target;
    } ex_redirect_t;

endpackage

/* src/ex_issue_reg.sv */
`timescale 1ns/1ps

module ex_issue_reg
    import ex_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush_i,
    input  logic     req_valid_i,
    input  ex_req_t  req_i,
    input  logic     retire_i,
    output logic     issue_valid_o,
    output ex_req_t  issue_req_o,
    output ex_path_e issue_path_o,
    output logic     mul_start_o,
    output logic     div_start_o,
    output logic     ready_o
);

    ex_req_t  req_q;
    ex_path_e path_q;
    ex_path_e path_d;
    logic     valid_q;
    logic     busy_q;
    logic     mul_start_q;
    logic     div_start_q;
    logic     capture;

    always_comb begin
        case (req_i.op)
            OP_MUL, OP_MULH, OP_MULHU:        path_d = PATH_MUL;
            OP_DIV, OP_DIVU, OP_MOD, OP_MODU: path_d = PATH_DIV;
            default:                          path_d = PATH_ALU;
        endcase
    end

    assign capture = req_valid_i && !busy_q;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q     <= 1'b0;
            busy_q      <= 1'b0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= capture && (path_d == PATH_MUL);
            div_start_q <= capture && (path_d == PATH_DIV);
            if (capture) begin
                valid_q <= 1'b1;
                busy_q  <= (path_d != PATH_ALU);
            end else if (retire_i || !busy_q) begin
                // Long op finished, or a one-cycle ALU slot expires
                valid_q <= 1'b0;
                busy_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req_q  <= req_i;
            path_q <= path_d;
        end
    end

    assign issue_valid_o = valid_q;
    assign issue_req_o   = req_q;
    assign issue_path_o  = path_q;
    assign mul_start_o   = mul_start_q;
    assign div_start_o   = div_start_q;
    assign ready_o       = !busy_q;

endmodule

/* src/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu
    import ex_pkg::*;
(
    input  ex_op_e          op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] result_o,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o
);

    logic [XLEN-1:0] link_pc;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign link_pc     = pc_i + XLEN'(4);
    assign shamt       = src2_i[4:0];
    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = src1_i + src2_i;
            OP_SUB:  result_o = src1_i - src2_i;
            OP_AND:  result_o = src1_i & src2_i;
            OP_OR:   result_o = src1_i | src2_i;
            OP_XOR:  result_o = src1_i ^ src2_i;
            OP_SLL:  result_o = src1_i << shamt;
            OP_SRL:  result_o = src1_i >> shamt;
            OP_SRA:  result_o = $unsigned($signed(src1_i) >>> shamt);
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            OP_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            OP_LUI:  result_o = src2_i;
            OP_JAL:  result_o = link_pc;
            // Conditional branches write nothing
            default: result_o = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            OP_BEQ:  taken_o = (src1_i == src2_i);
            OP_BNE:  taken_o = (src1_i != src2_i);
            OP_BLT:  taken_o = lt_signed;
            OP_BLTU: taken_o = lt_unsigned;
            OP_JAL:  taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    // Fall-through when not taken
    assign target_o = taken_o ? (pc_i + imm_i) : link_pc;

endmodule

/* src/ex_mul_unit.sv */
`timescale 1ns/1ps

module ex_mul_unit
    import ex_pkg::*;
#(
    parameter int unsigned MUL_PIPE_STAGES = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start_i,
    input  ex_op_e          op_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic            done_o,
    output logic [XLEN-1:0] product_o
);

    typedef struct packed {
        logic              hi;
        logic [2*XLEN-1:0] prod;
    } mul_data_t;

    logic [MUL_PIPE_STAGES-1:0] valid_q;
    mul_data_t                  data_q [MUL_PIPE_STAGES];
    logic signed [XLEN:0]       a_ext;
    logic signed [XLEN:0]       b_ext;
    logic signed [2*XLEN+1:0]   full;
    mul_data_t                  data_d;

    // One extra bit selects signed or unsigned with a single multiplier
    assign a_ext = {(op_i == OP_MULH) && src1_i[XLEN-1], src1_i};
    assign b_ext = {(op_i == OP_MULH) && src2_i[XLEN-1], src2_i};
    assign full  = a_ext * b_ext;

    assign data_d.hi   = (op_i != OP_MUL);
    assign data_d.prod = full[2*XLEN-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= start_i;
            for (int i = 1; i < MUL_PIPE_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= data_d;
        for (int i = 1; i < MUL_PIPE_STAGES; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign done_o    = valid_q[MUL_PIPE_STAGES-1];
    assign product_o = data_q[MUL_PIPE_STAGES-1].hi ? data_q[MUL_PIPE_STAGES-1].prod[2*XLEN-1:XLEN]
                                                    : data_q[MUL_PIPE_STAGES-1].prod[XLEN-1:0];

endmodule

/* src/ex_div_unit.sv */
`timescale 1ns/1ps

module ex_div_unit
    import ex_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            start_i,
    input  ex_op_e          op_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic            done_o,
    output logic [XLEN-1:0] result_o
);

    logic            busy_q;
    logic            done_q;
    logic [4:0]      step_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] dsr_q;
    logic [XLEN-1:0] dividend_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            sel_rem_q;
    logic            zero_q;
    logic            is_signed;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;

    assign is_signed = (op_i == OP_DIV) || (op_i == OP_MOD);
    assign abs_a     = (is_signed && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign abs_b     = (is_signed && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

    // One restoring step, bit XLEN of diff is the borrow
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 5'd1;
                if (step_q == 5'(XLEN-1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q      <= '0;
            quo_q      <= abs_a;
            dsr_q      <= abs_b;
            dividend_q <= dividend_i;
            neg_quo_q  <= is_signed && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            neg_rem_q  <= is_signed && dividend_i[XLEN-1];
            sel_rem_q  <= (op_i == OP_MOD) || (op_i == OP_MODU);
            zero_q     <= (divisor_i == '0);
        end else if (busy_q) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // Most negative by -1 needs no special case, the negated quotient wraps
    // back to the dividend and the remainder is already zero
    assign quo_fix = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fix = zero_q ? dividend_q : (neg_rem_q ? -rem_q : rem_q);

    assign done_o   = done_q;
    assign result_o = sel_rem_q ? rem_fix : quo_fix;

endmodule

/* src/ex_result_stage.sv */
`timescale 1ns/1ps

module ex_result_stage
    import ex_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            issue_valid_i,
    input  ex_req_t         issue_req_i,
    input  ex_path_e        issue_path_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic            taken_i,
    input  logic [XLEN-1:0] target_i,
    input  logic            mul_done_i,
    input  logic [XLEN-1:0] mul_result_i,
    input  logic            div_done_i,
    input  logic [XLEN-1:0] div_result_i,
    output logic            retire_o,
    output logic            res_valid_o,
    output ex_result_t      res_o,
    output logic            redirect_o,
    output ex_redirect_t    redirect_target_o
);

    logic       alu_fire;
    logic       fire;
    logic       is_cond_branch;
    logic       is_branch;
    logic       mispredict;
    ex_result_t res_d;

    assign is_cond_branch = (issue_req_i.op == OP_BEQ) || (issue_req_i.op == OP_BNE)
                         || (issue_req_i.op == OP_BLT) || (issue_req_i.op == OP_BLTU);
    assign is_branch      = is_cond_branch || (issue_req_i.op == OP_JAL);

    assign alu_fire = issue_valid_i && (issue_path_i == PATH_ALU);
    assign retire_o = issue_valid_i
                   && (((issue_path_i == PATH_MUL) && mul_done_i)
                    || ((issue_path_i == PATH_DIV) && div_done_i));
    assign fire     = alu_fire || retire_o;

    assign mispredict = alu_fire && is_branch && (taken_i != issue_req_i.pred_taken);

    always_comb begin
        res_d.pc  = issue_req_i.pc;
        res_d.rd  = issue_req_i.rd;
        res_d.wen = issue_req_i.wen && !is_cond_branch;
        case (issue_path_i)
            PATH_MUL: res_d.wdata = mul_result_i;
            PATH_DIV: res_d.wdata = div_result_i;
            default:  res_d.wdata = alu_result_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register toward memory stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            res_valid_o <= 1'b0;
            redirect_o  <= 1'b0;
        end else begin
            res_valid_o <= fire;
            redirect_o  <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_o <= res_d;
        end
        if (mispredict) begin
            redirect_target_o.branch_pc <= issue_req_i.pc;
            redirect_target_o.target    <= target_i;
        end
    end

endmodule

/* src/ex_stage_top.sv */
`timescale 1ns/1ps

module ex_stage_top
    import ex_pkg::*;
#(
    parameter int unsigned MUL_PIPE_STAGES = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush_i,
    input  logic         req_valid_i,
    input  ex_req_t      req_i,
    output logic         ready_o,
    output logic         res_valid_o,
    output ex_result_t   res_o,
    output logic         redirect_o,
    output ex_redirect_t redirect_target_o
);

    logic            issue_valid;
    ex_req_t         issue_req;
    ex_path_e        issue_path;
    logic            mul_start;
    logic            div_start;
    logic            retire;
    logic [XLEN-1:0] alu_result;
    logic            alu_taken;
    logic [XLEN-1:0] alu_target;
    logic            mul_done;
    logic [XLEN-1:0] mul_result;
    logic            div_done;
    logic [XLEN-1:0] div_result;
    logic            mul_clear;

    // A flushed multiply must not surface after a later issue
    assign mul_clear = rst || flush_i;

    ex_issue_reg u_issue (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .retire_i      (retire),
        .issue_valid_o (issue_valid),
        .issue_req_o   (issue_req),
        .issue_path_o  (issue_path),
        .mul_start_o   (mul_start),
        .div_start_o   (div_start),
        .ready_o       (ready_o)
    );

    ex_alu u_alu (
        .op_i     (issue_req.op),
        .pc_i     (issue_req.pc),
        .src1_i   (issue_req.src1),
        .src2_i   (issue_req.src2),
        .imm_i    (issue_req.imm),
        .result_o (alu_result),
        .taken_o  (alu_taken),
        .target_o (alu_target)
    );

    ex_mul_unit #(
        .MUL_PIPE_STAGES (MUL_PIPE_STAGES)
    ) u_mul (
        .clk       (clk),
        .rst       (mul_clear),
        .start_i   (mul_start),
        .op_i      (issue_req.op),
        .src1_i    (issue_req.src1),
        .src2_i    (issue_req.src2),
        .done_o    (mul_done),
        .product_o (mul_result)
    );

    ex_div_unit u_div (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .start_i    (div_start),
        .op_i       (issue_req.op),
        .dividend_i (issue_req.src1),
        .divisor_i  (issue_req.src2),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    ex_result_stage u_result (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (flush_i),
        .issue_valid_i     (issue_valid),
        .issue_req_i       (issue_req),
        .issue_path_i      (issue_path),
        .alu_result_i      (alu_result),
        .taken_i           (alu_taken),
        .target_i          (alu_target),
        .mul_done_i        (mul_done),
        .mul_result_i      (mul_result),
        .div_done_i        (div_done),
        .div_result_i      (div_result),
        .retire_o          (retire),
        .res_valid_o       (res_valid_o),
        .res_o             (res_o),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o)
    );

endmodule

/* verification/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

function automatic logic is_cond_branch(ex_op_e op);
    return (op == OP_BEQ) || (op == OP_BNE) || (op == OP_BLT) || (op == OP_BLTU);
endfunction

function automatic logic is_branch(ex_op_e op);
    return is_cond_branch(op) || (op == OP_JAL);
endfunction

function automatic logic is_long_op(ex_op_e op);
    return (op >= OP_MUL) && (op <= OP_MODU);
endfunction

// Edges from strobe to result or -1 for a variable latency
function automatic int fixed_latency(ex_op_e op, int mul_stages);
    if ((op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHU)) begin
        return mul_stages + 2;
    end
    if (is_long_op(op)) begin
        return -1;
    end
    return 2;
endfunction

function automatic logic [XLEN-1:0] expected_wdata(ex_req_t r);
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [2*XLEN-1:0]      ua;
    logic [2*XLEN-1:0]      ub;
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    logic [2*XLEN-1:0]      wide;
    logic signed [XLEN-1:0] sdiv_a;
    logic signed [XLEN-1:0] sdiv_b;
    logic signed [XLEN-1:0] squo;
    logic signed [XLEN-1:0] srem;
    logic                   ovf;
    a      = r.src1;
    b      = r.src2;
    ua     = {{XLEN{1'b0}}, a};
    ub     = {{XLEN{1'b0}}, b};
    sa     = {{XLEN{a[XLEN-1]}}, a};
    sb     = {{XLEN{b[XLEN-1]}}, b};
    sdiv_a = a;
    sdiv_b = b;
    ovf    = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    squo   = '0;
    srem   = '0;
    // Signed quotient and remainder of a legal divide
    if ((b != '0) && !ovf) begin
        squo = sdiv_a / sdiv_b;
        srem = sdiv_a % sdiv_b;
    end
    case (r.op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLL:  return a << b[4:0];
        OP_SRL:  return a >> b[4:0];
        OP_SRA: begin
            wide = sa >> b[4:0];
            return wide[XLEN-1:0];
        end
        OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
        OP_LUI:  return b;
        OP_MUL: begin
            wide = ua * ub;
            return wide[XLEN-1:0];
        end
        OP_MULH: begin
            wide = sa * sb;
            return wide[2*XLEN-1:XLEN];
        end
        OP_MULHU: begin
            wide = ua * ub;
            return wide[2*XLEN-1:XLEN];
        end
        OP_DIV:  return (b == '0) ? '1 : (ovf ? a : squo);
        OP_DIVU: return (b == '0) ? '1 : a / b;
        OP_MOD:  return (b == '0) ? a : (ovf ? '0 : srem);
        OP_MODU: return (b == '0) ? a : a % b;
        OP_JAL:  return r.pc + 32'd4;
        default: return '0;
    endcase
endfunction

function automatic logic branch_taken(ex_req_t r);
    case (r.op)
        OP_BEQ:  return r.src1 == r.src2;
        OP_BNE:  return r.src1 != r.src2;
        OP_BLT:  return $signed(r.src1) < $signed(r.src2);
        OP_BLTU: return r.src1 < r.src2;
        OP_JAL:  return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [XLEN-1:0] branch_target(ex_req_t r);
    return branch_taken(r) ? (r.pc + r.imm) : (r.pc + 32'd4);
endfunction

`endif

/* verification/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
();

    `include "ex_ref_model.svh"

    localparam int MUL_STAGES     = 2;
    localparam int TIMEOUT_CYCLES = 600 * 40;
    localparam int KIND_ALU       = 0;
    localparam int KIND_MUL       = 1;
    localparam int KIND_DIV       = 2;
    localparam int KIND_BR        = 3;

    typedef struct packed {
        ex_result_t   res;
        logic         redir_en;
        ex_redirect_t redir;
        logic         long_op;
        int           due_edge;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         flush_i;
    logic         req_valid_i;
    ex_req_t      req_i;
    logic         ready_o;
    logic         res_valid_o;
    ex_result_t   res_o;
    logic         redirect_o;
    ex_redirect_t redirect_target_o;

    expect_t      exp_q[$];
    logic         long_pending = 1'b0;
    int           seed         = 32'hf272;
    int           cycle_cnt    = 0;
    int           value_errs   = 0;
    int           proto_errs   = 0;

    ex_stage_top #(
        .MUL_PIPE_STAGES (MUL_STAGES)
    ) UUT (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (flush_i),
        .req_valid_i       (req_valid_i),
        .req_i             (req_i),
        .ready_o           (ready_o),
        .res_valid_o       (res_valid_o),
        .res_o             (res_o),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o)
    );

    always #4 clk = ~clk;

    // Edge counter and watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_result(string name, ex_result_t got, ex_result_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_redirect(string name, ex_redirect_t got, ex_redirect_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Outputs are settled by the falling edge
    task automatic sample_outputs();
        expect_t e;
        if (res_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("Result for pc %h appeared with no request outstanding", res_o.pc);
            end else begin
                e = exp_q.pop_front();
                check_result("res_o", res_o, e.res);
                if ((e.due_edge >= 0) && (cycle_cnt != e.due_edge)) begin
                    proto_errs++;
                    $display("Result for pc %h came at edge %0d instead of edge %0d",
                             e.res.pc, cycle_cnt, e.due_edge);
                end
                if (e.long_op) begin
                    long_pending = 1'b0;
                end
                if (e.redir_en) begin
                    if (redirect_o !== 1'b1) begin
                        proto_errs++;
                        $display("Missing redirect for mispredicted branch at pc %h", e.res.pc);
                    end else begin
                        check_redirect("redirect_target_o", redirect_target_o, e.redir);
                    end
                end else if (redirect_o !== 1'b0) begin
                    proto_errs++;
                    $display("Redirect raised for pc %h with a correct prediction", e.res.pc);
                end
            end
        end else if (res_valid_o !== 1'b0) begin
            proto_errs++;
            $display("res_valid_o is unknown at edge %0d", cycle_cnt);
        end else if (redirect_o !== 1'b0) begin
            proto_errs++;
            $display("Redirect raised without a result at edge %0d", cycle_cnt);
        end
        check_bit("ready_o", ready_o, !long_pending);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic tick();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] rand32();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = rand32();
        return int'(r % 32'(n));
    endfunction

    function automatic ex_req_t random_req(int kind);
        ex_req_t r;
        int      pick;
        int      corner;
        r.pc         = rand32() & ~32'h3;
        r.src1       = rand32();
        r.src2       = rand32();
        r.imm        = rand32() & ~32'h1;
        r.rd         = 5'(rand_below(32));
        r.wen        = (rand_below(4) != 0);
        r.pred_taken = (rand_below(2) == 1);
        corner       = rand_below(8);
        case (kind)
            KIND_MUL: pick = int'(OP_MUL) + rand_below(3);
            KIND_DIV: begin
                pick = int'(OP_DIV) + rand_below(4);
                if (corner == 0) begin
                    r.src2 = '0;
                end else if (corner == 1) begin
                    r.src1 = 32'h8000_0000;
                    r.src2 = 32'hffff_ffff;
                end else if (corner == 2) begin
                    r.src2 = r.src2 & 32'h0000_00ff;
                end
            end
            KIND_BR: begin
                pick = int'(OP_BEQ) + rand_below(5);
                // Equal operands so that beq and bne go both ways
                if (corner < 3) begin
                    r.src2 = r.src1;
                end
            end
            default: pick = rand_below(11);
        endcase
        r.op = ex_op_e'(5'(pick));
        return r;
    endfunction

    task automatic send(ex_req_t r);
        expect_t e;
        int      lat;
        while (ready_o !== 1'b1) begin
            tick();
        end
        req_valid_i = 1'b1;
        req_i       = r;
        tick();
        req_valid_i = 1'b0;
        e.res.pc       = r.pc;
        e.res.rd       = r.rd;
        e.res.wen      = r.wen && !is_cond_branch(r.op);
        e.res.wdata    = expected_wdata(r);
        e.redir_en     = is_branch(r.op) && (branch_taken(r) != r.pred_taken);
        e.redir.branch_pc = r.pc;
        e.redir.target    = branch_target(r);
        e.long_op      = is_long_op(r.op);
        lat            = fixed_latency(r.op, MUL_STAGES);
        // cycle_cnt now holds the capture edge
        e.due_edge     = (lat > 0) ? cycle_cnt + lat - 1 : -1;
        if (e.long_op) begin
            long_pending = 1'b1;
        end
        exp_q.push_back(e);
    endtask

    task automatic flush_pipe();
        flush_i     = 1'b1;
        req_valid_i = 1'b0;
        tick();
        flush_i     = 1'b0;
        exp_q.delete();
        long_pending = 1'b0;
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while ((exp_q.size() > 0) && (guard < 100)) begin
            tick();
            guard++;
        end
        tick();
    endtask

    task automatic run_phase(int kind, int count);
        repeat (count) begin
            send(random_req(kind));
        end
        drain();
    endtask

    initial begin
        rst         = 1'b1;
        flush_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();

        run_phase(KIND_ALU, 200);
        run_phase(KIND_MUL, 80);
        run_phase(KIND_DIV, 60);
        run_phase(KIND_BR, 160);

        // Flush at random points and often in the middle of a divide
        repeat (40) begin
            send(random_req(rand_below(4)));
            repeat (rand_below(40)) begin
                tick();
            end
            flush_pipe();
            send(random_req(rand_below(4)));
        end
        drain();

        if (exp_q.size() != 0) begin
            proto_errs++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
        if ((value_errs == 0) && (proto_errs == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+verification
src/ex_pkg.sv
src/ex_issue_reg.sv
src/ex_alu.sv
src/ex_mul_unit.sv
src/ex_div_unit.sv
src/ex_result_stage.sv
src/ex_stage_top.sv
verification/tb_ex_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SRCS := $(wildcard src/*.sv) verification/tb_ex_stage.sv verification/ex_ref_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
